//--- hdl/exec_pkg.sv
package exec_pkg;

    // Data path and instruction field widths.
    localparam int XLEN    = 64;
    localparam int REG_W   = 5;
    localparam int INST_W  = 32;
    localparam int SHAMT_W = 5;
    localparam int IMM_W   = 16;
    localparam int HALF_W  = XLEN / 2;

    // Position of the shift amount inside the instruction word.
    localparam int SHAMT_LSB = 6;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [REG_W-1:0]   regnum_t;
    typedef logic [INST_W-1:0]  inst_t;
    typedef logic [SHAMT_W-1:0] shamt_t;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        NOR = 3'd5
    } alu_op_t;

    // Second ALU operand.
    typedef enum logic [1:0] {
        REG      = 2'd0,
        SIGN_IMM = 2'd1,
        ZERO_IMM = 2'd2
    } src2_t;

    // Where a source operand is taken from.
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_t;

    typedef enum logic [1:0] {
        SLT_NONE     = 2'd0,
        SLT_SIGNED   = 2'd1,
        SLT_UNSIGNED = 2'd2
    } slt_t;

    // Half-word move applied after the shifter.
    typedef enum logic [1:0] {
        P32_NONE  = 2'd0,
        P32_LEFT  = 2'd1,
        P32_RIGHT = 2'd2
    } plus32_t;

endpackage

//--- hdl/alu.sv
`timescale 1ns/10ps

module alu import exec_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t alu_op,
    output word_t   out,
    output logic    overflow,
    output logic    zero,
    output logic    negative,
    output logic    borrow_out
);
    word_t sum;
    word_t diff;
    logic  borrow;
    logic  add_overflow;
    logic  sub_overflow;

    assign sum = a + b;

    // The extra top bit of the unsigned difference is the borrow.
    assign {borrow, diff} = {1'b0, a} - {1'b0, b};

    // Add overflows when both operands share a sign that the sum does not.
    assign add_overflow = (a[XLEN-1] == b[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);

    // Subtract overflows when the signs differ and the result takes the sign of b.
    assign sub_overflow = (a[XLEN-1] != b[XLEN-1]) && (diff[XLEN-1] != a[XLEN-1]);

    always_comb begin
        out        = '0;
        overflow   = 1'b0;
        borrow_out = 1'b0;
        case (alu_op)
            ADD: begin
                out      = sum;
                overflow = add_overflow;
            end
            SUB: begin
                out        = diff;
                overflow   = sub_overflow;
                borrow_out = borrow;
            end
            AND: begin
                out = a & b;
            end
            OR: begin
                out = a | b;
            end
            XOR: begin
                out = a ^ b;
            end
            NOR: begin
                out = ~(a | b);
            end
            default: begin
                out = '0;
            end
        endcase
    end

    // Flags follow the selected result.
    assign zero     = (out == '0);
    assign negative = out[XLEN-1];

endmodule

//--- hdl/barrel_shifter.sv
`timescale 1ns/10ps

module barrel_shifter import exec_pkg::*; (
    input  word_t  data,
    input  shamt_t shamt,
    input  logic   shift_right,
    output word_t  out
);
    word_t shifted;

    // Stage i moves the value by 2**i when amount bit i is set.
    // Zeros enter from the side opposite the shift direction.
    always_comb begin
        shifted = data;
        for (int i = 0; i < SHAMT_W; i++) begin
            if (shamt[i]) begin
                if (shift_right) begin
                    shifted = shifted >> (1 << i);
                end else begin
                    shifted = shifted << (1 << i);
                end
            end
        end
    end

    assign out = shifted;

endmodule

//--- hdl/forward_unit.sv
`timescale 1ns/10ps

module forward_unit import exec_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  regnum_t a_regnum,
    input  regnum_t b_regnum,
    input  word_t   ex_out,
    input  regnum_t ex_w_regnum,
    input  logic    ex_write_enable,
    output fwd_t    forward_a,
    output fwd_t    forward_b,
    output word_t   mem_data,
    output regnum_t mem_w_regnum
);
    logic mem_write_enable;

    // MEM copy of the EX register, one cycle behind it.
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            mem_data         <= '0;
            mem_w_regnum     <= '0;
            mem_write_enable <= 1'b0;
        end else begin
            mem_data         <= ex_out;
            mem_w_regnum     <= ex_w_regnum;
            mem_write_enable <= ex_write_enable;
        end
    end

    // Register zero is hardwired, so it never matches.
    function automatic logic hits(
        input regnum_t src,
        input regnum_t dst,
        input logic    we
    );
        return we && (dst != '0) && (dst == src);
    endfunction

    // The younger EX result wins over the MEM copy.
    function automatic fwd_t pick_source(
        input regnum_t src,
        input regnum_t ex_dst,
        input logic    ex_we,
        input regnum_t mem_dst,
        input logic    mem_we
    );
        fwd_t sel;
        if (hits(src, ex_dst, ex_we)) begin
            sel = FWD_EX;
        end else if (hits(src, mem_dst, mem_we)) begin
            sel = FWD_MEM;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        forward_a = pick_source(a_regnum, ex_w_regnum, ex_write_enable,
                                mem_w_regnum, mem_write_enable);
        forward_b = pick_source(b_regnum, ex_w_regnum, ex_write_enable,
                                mem_w_regnum, mem_write_enable);
    end

endmodule

//--- hdl/exec_stage.sv
`timescale 1ns/10ps

module exec_stage import exec_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    flush,
    input  inst_t   inst,
    input  word_t   a_data,
    input  word_t   b_data,
    input  regnum_t w_regnum,
    input  logic    write_enable,
    input  alu_op_t alu_op,
    input  src2_t   alu_src2,
    input  slt_t    slt_type,
    input  logic    cut_alu_out32,
    input  logic    shift_right,
    input  logic    cut_shifter_out32,
    input  plus32_t shifter_plus32,
    input  logic    alu_shifter_src,
    input  logic    lui,
    input  fwd_t    forward_a,
    input  fwd_t    forward_b,
    input  word_t   mem_data,
    output word_t   ex_out,
    output word_t   ex_b_data,
    output regnum_t ex_w_regnum,
    output logic    ex_write_enable,
    output logic    ex_overflow,
    output logic    ex_zero,
    output word_t   ex_slt_out
);
    word_t fwd_a;
    word_t fwd_b;
    word_t b_in;
    word_t sign_imm;
    word_t zero_imm;
    word_t alu_raw;
    word_t alu_res;
    word_t shift_raw;
    word_t shift_cut;
    word_t shift_res;
    word_t shaped;
    word_t result;
    word_t slt_val;
    logic  overflow;
    logic  zero;
    logic  negative;
    logic  borrow;
    logic  signs_differ;
    logic  less_signed;

    assign sign_imm = {{(XLEN-IMM_W){inst[IMM_W-1]}}, inst[IMM_W-1:0]};
    assign zero_imm = {{(XLEN-IMM_W){1'b0}}, inst[IMM_W-1:0]};

    function automatic word_t pick_fwd(input fwd_t sel, input word_t reg_val,
                                       input word_t ex_val, input word_t mem_val);
        word_t val;
        case (sel)
            FWD_EX:  val = ex_val;
            FWD_MEM: val = mem_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    always_comb begin
        fwd_a = pick_fwd(forward_a, a_data, ex_out, mem_data);
        fwd_b = pick_fwd(forward_b, b_data, ex_out, mem_data);
        case (alu_src2)
            SIGN_IMM: b_in = sign_imm;
            ZERO_IMM: b_in = zero_imm;
            default:  b_in = fwd_b;
        endcase
    end

    alu i_alu (
        .a          (fwd_a),
        .b          (b_in),
        .alu_op     (alu_op),
        .out        (alu_raw),
        .overflow   (overflow),
        .zero       (zero),
        .negative   (negative),
        .borrow_out (borrow)
    );

    barrel_shifter i_shifter (
        .data        (fwd_b),
        .shamt       (inst[SHAMT_LSB +: SHAMT_W]),
        .shift_right (shift_right),
        .out         (shift_raw)
    );

    // Word operations keep only the low half, sign extended.
    assign alu_res   = cut_alu_out32 ? {{HALF_W{alu_raw[HALF_W-1]}}, alu_raw[HALF_W-1:0]}
                                     : alu_raw;
    assign shift_cut = cut_shifter_out32
                     ? {{HALF_W{shift_raw[HALF_W-1]}}, shift_raw[HALF_W-1:0]}
                     : shift_raw;

    always_comb begin
        case (shifter_plus32)
            P32_LEFT:  shift_res = {shift_cut[HALF_W-1:0], {HALF_W{1'b0}}};
            P32_RIGHT: shift_res = {{HALF_W{1'b0}}, shift_cut[XLEN-1:HALF_W]};
            default:   shift_res = shift_cut;
        endcase
    end

    assign shaped = alu_shifter_src ? shift_res : alu_res;
    assign result = lui ? (sign_imm << IMM_W) : shaped;

    // With equal signs the difference cannot overflow, so its sign decides.
    assign signs_differ = fwd_a[XLEN-1] ^ b_in[XLEN-1];
    assign less_signed  = signs_differ ? fwd_a[XLEN-1] : negative;

    always_comb begin
        case (slt_type)
            SLT_SIGNED:   slt_val = word_t'(less_signed);
            SLT_UNSIGNED: slt_val = word_t'(borrow);
            default:      slt_val = result;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ex_out          <= '0;
            ex_b_data       <= '0;
            ex_w_regnum     <= '0;
            ex_write_enable <= 1'b0;
            ex_overflow     <= 1'b0;
            ex_zero         <= 1'b0;
            ex_slt_out      <= '0;
        end else if (flush) begin
            ex_out          <= '0;
            ex_b_data       <= '0;
            ex_w_regnum     <= '0;
            ex_write_enable <= 1'b0;
            ex_overflow     <= 1'b0;
            ex_zero         <= 1'b0;
            ex_slt_out      <= '0;
        end else begin
            ex_out          <= result;
            ex_b_data       <= fwd_b;
            ex_w_regnum     <= w_regnum;
            ex_write_enable <= write_enable;
            ex_overflow     <= overflow;
            ex_zero         <= zero;
            ex_slt_out      <= slt_val;
        end
    end

endmodule

//--- hdl/exec_top.sv
`timescale 1ns/10ps

module exec_top import exec_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    flush,
    input  inst_t   inst,
    input  word_t   a_data,
    input  word_t   b_data,
    input  regnum_t a_regnum,
    input  regnum_t b_regnum,
    input  regnum_t w_regnum,
    input  logic    write_enable,
    input  alu_op_t alu_op,
    input  src2_t   alu_src2,
    input  slt_t    slt_type,
    input  logic    cut_alu_out32,
    input  logic    shift_right,
    input  logic    cut_shifter_out32,
    input  plus32_t shifter_plus32,
    input  logic    alu_shifter_src,
    input  logic    lui,
    output word_t   ex_out,
    output word_t   ex_b_data,
    output regnum_t ex_w_regnum,
    output logic    ex_write_enable,
    output logic    ex_overflow,
    output logic    ex_zero,
    output word_t   ex_slt_out,
    output word_t   mem_data,
    output regnum_t mem_w_regnum
);
    fwd_t forward_a;
    fwd_t forward_b;

    forward_unit i_forward (
        .clock           (clock),
        .reset           (reset),
        .a_regnum        (a_regnum),
        .b_regnum        (b_regnum),
        .ex_out          (ex_out),
        .ex_w_regnum     (ex_w_regnum),
        .ex_write_enable (ex_write_enable),
        .forward_a       (forward_a),
        .forward_b       (forward_b),
        .mem_data        (mem_data),
        .mem_w_regnum    (mem_w_regnum)
    );

    exec_stage i_exec (
        .clock             (clock),
        .reset             (reset),
        .flush             (flush),
        .inst              (inst),
        .a_data            (a_data),
        .b_data            (b_data),
        .w_regnum          (w_regnum),
        .write_enable      (write_enable),
        .alu_op            (alu_op),
        .alu_src2          (alu_src2),
        .slt_type          (slt_type),
        .cut_alu_out32     (cut_alu_out32),
        .shift_right       (shift_right),
        .cut_shifter_out32 (cut_shifter_out32),
        .shifter_plus32    (shifter_plus32),
        .alu_shifter_src   (alu_shifter_src),
        .lui               (lui),
        .forward_a         (forward_a),
        .forward_b         (forward_b),
        .mem_data          (mem_data),
        .ex_out            (ex_out),
        .ex_b_data         (ex_b_data),
        .ex_w_regnum       (ex_w_regnum),
        .ex_write_enable   (ex_write_enable),
        .ex_overflow       (ex_overflow),
        .ex_zero           (ex_zero),
        .ex_slt_out        (ex_slt_out)
    );

endmodule

//--- tests/tb_exec_top.sv
`timescale 1ns/10ps

module tb_exec_top import exec_pkg::*; ();

    localparam int N_INSTR = 400;

    typedef struct packed {
        inst_t   inst;
        regnum_t a_regnum;
        regnum_t b_regnum;
        regnum_t w_regnum;
        logic    write_enable;
        alu_op_t alu_op;
        src2_t   alu_src2;
        slt_t    slt_type;
        logic    cut_alu_out32;
        logic    shift_right;
        logic    cut_shifter_out32;
        plus32_t shifter_plus32;
        logic    alu_shifter_src;
        logic    lui;
        logic    flush;
        logic    reset;
    } instr_t;

    // One expected EX register entry plus the MEM copy seen with it.
    typedef struct packed {
        word_t   out;
        word_t   b_data;
        regnum_t w_regnum;
        logic    we;
        logic    overflow;
        logic    zero;
        word_t   slt;
        word_t   mem_data;
        regnum_t mem_w_regnum;
    } exp_t;

    logic    clock = 1'b0;
    logic    reset;
    logic    flush;
    inst_t   inst;
    word_t   a_data;
    word_t   b_data;
    regnum_t a_regnum;
    regnum_t b_regnum;
    regnum_t w_regnum;
    logic    write_enable;
    alu_op_t alu_op;
    src2_t   alu_src2;
    slt_t    slt_type;
    logic    cut_alu_out32;
    logic    shift_right;
    logic    cut_shifter_out32;
    plus32_t shifter_plus32;
    logic    alu_shifter_src;
    logic    lui;
    word_t   ex_out;
    word_t   ex_b_data;
    regnum_t ex_w_regnum;
    logic    ex_write_enable;
    logic    ex_overflow;
    logic    ex_zero;
    word_t   ex_slt_out;
    word_t   mem_data;
    regnum_t mem_w_regnum;

    word_t       regfile [32];
    exp_t        ex_sh;
    exp_t        mem_sh;
    exp_t        expected [$];
    exp_t        want;
    instr_t      t;
    logic [31:0] rng_state = 32'hddfb;
    int          slots = 0;
    int          checks = 0;
    int          errors = 0;

    exec_top i_dut (.*);

    always #5 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Register zero and non-writing entries never forward.
    function automatic word_t forwarded(input regnum_t src, input word_t reg_val);
        if (ex_sh.we && ex_sh.w_regnum != '0 && ex_sh.w_regnum == src) return ex_sh.out;
        if (mem_sh.we && mem_sh.w_regnum != '0 && mem_sh.w_regnum == src) return mem_sh.out;
        return reg_val;
    endfunction

    function automatic exp_t reference(input instr_t i, input word_t a_reg, input word_t b_reg);
        exp_t          e;
        word_t         a;
        word_t         b;
        word_t         b_in;
        word_t         imm_s;
        word_t         alu_res;
        word_t         sh;
        logic [XLEN:0] ea;
        logic [XLEN:0] eb;
        logic [XLEN:0] wide;
        e = '0;
        a = forwarded(i.a_regnum, a_reg);
        b = forwarded(i.b_regnum, b_reg);
        imm_s = word_t'($signed(i.inst[15:0]));
        case (i.alu_src2)
            SIGN_IMM: b_in = imm_s;
            ZERO_IMM: b_in = word_t'(i.inst[15:0]);
            default:  b_in = b;
        endcase
        // One extra sign bit shows signed overflow as a mismatch of the top two bits.
        ea = {a[XLEN-1], a};
        eb = {b_in[XLEN-1], b_in};
        case (i.alu_op)
            ADD:     wide = ea + eb;
            SUB:     wide = ea - eb;
            AND:     wide = ea & eb;
            OR:      wide = ea | eb;
            XOR:     wide = ea ^ eb;
            default: wide = ~(ea | eb);
        endcase
        alu_res    = wide[XLEN-1:0];
        e.overflow = wide[XLEN] ^ wide[XLEN-1];
        e.zero     = (alu_res == '0);
        sh = i.shift_right ? (b >> i.inst[10:6]) : (b << i.inst[10:6]);
        if (i.cut_shifter_out32) sh = word_t'($signed(sh[31:0]));
        if (i.shifter_plus32 == P32_LEFT) sh = sh << 32;
        if (i.shifter_plus32 == P32_RIGHT) sh = sh >> 32;
        if (i.cut_alu_out32) alu_res = word_t'($signed(alu_res[31:0]));
        e.out = i.lui ? (imm_s << 16) : (i.alu_shifter_src ? sh : alu_res);
        case (i.slt_type)
            SLT_SIGNED:   e.slt = word_t'((a[63] != b_in[63]) ? a[63] : wide[63]);
            SLT_UNSIGNED: e.slt = word_t'(i.alu_op == SUB && a < b_in);
            default:      e.slt = e.out;
        endcase
        e.b_data   = b;
        e.w_regnum = i.w_regnum;
        e.we       = i.write_enable;
        return e;
    endfunction

    function automatic instr_t alu_instr(input alu_op_t op, input src2_t src, input slt_t slt,
                                         input regnum_t ra, input regnum_t rb,
                                         input regnum_t rd, input logic [15:0] imm);
        instr_t i;
        i = '0;
        i.alu_op = op;
        i.alu_src2 = src;
        i.slt_type = slt;
        i.a_regnum = ra;
        i.b_regnum = rb;
        i.w_regnum = rd;
        i.write_enable = 1'b1;
        i.inst[15:0] = imm;
        return i;
    endfunction

    function automatic instr_t shift_instr(input regnum_t rb, input shamt_t amt,
                                           input logic right, input logic cut,
                                           input plus32_t p32);
        instr_t i;
        i = alu_instr(ADD, REG, SLT_NONE, 5'd0, rb, 5'd21, 16'h0);
        i.inst[10:6] = amt;
        i.shift_right = right;
        i.cut_shifter_out32 = cut;
        i.shifter_plus32 = p32;
        i.alu_shifter_src = 1'b1;
        return i;
    endfunction

    function automatic instr_t random_instr();
        instr_t      i;
        logic [31:0] r;
        logic [31:0] s;
        r = rand32();
        s = rand32();
        i = '0;
        i.inst = rand32();
        i.a_regnum = {2'b0, r[2:0]};
        i.b_regnum = {2'b0, r[5:3]};
        i.w_regnum = {2'b0, r[8:6]};
        i.write_enable = r[9] | r[10];
        i.alu_op = alu_op_t'(r[13:11] % 3'd6);
        i.alu_src2 = src2_t'(r[15:14] % 2'd3);
        i.slt_type = slt_t'(r[17:16] % 2'd3);
        i.shifter_plus32 = plus32_t'(r[19:18] % 2'd3);
        i.cut_alu_out32 = r[20];
        i.shift_right = r[21];
        i.cut_shifter_out32 = r[22];
        i.alu_shifter_src = r[23];
        i.lui = (s[2:0] == 3'd0);
        i.flush = (s[6:3] == 4'd0);
        return i;
    endfunction

    task automatic apply(input instr_t i);
        reset = i.reset;
        flush = i.flush;
        inst = i.inst;
        a_regnum = i.a_regnum;
        b_regnum = i.b_regnum;
        a_data = regfile[i.a_regnum];
        b_data = regfile[i.b_regnum];
        w_regnum = i.w_regnum;
        write_enable = i.write_enable;
        alu_op = i.alu_op;
        alu_src2 = i.alu_src2;
        slt_type = i.slt_type;
        cut_alu_out32 = i.cut_alu_out32;
        shift_right = i.shift_right;
        cut_shifter_out32 = i.cut_shifter_out32;
        shifter_plus32 = i.shifter_plus32;
        alu_shifter_src = i.alu_shifter_src;
        lui = i.lui;
    endtask

    // Drives one slot and advances the shadow pipeline as the next edge will.
    task automatic issue(input instr_t i);
        exp_t e;
        @(negedge clock);
        apply(i);
        e = (i.reset || i.flush) ? '0 : reference(i, a_data, b_data);
        e.mem_data = i.reset ? '0 : ex_sh.out;
        e.mem_w_regnum = i.reset ? '0 : ex_sh.w_regnum;
        expected.push_back(e);
        if (i.reset) begin
            ex_sh = '0;
            mem_sh = '0;
        end else begin
            if (mem_sh.we && mem_sh.w_regnum != '0) regfile[mem_sh.w_regnum] = mem_sh.out;
            mem_sh = ex_sh;
            ex_sh = e;
        end
        slots++;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_regnum(input string name, input regnum_t got, input regnum_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    always @(posedge clock) begin
        #1;
        if (expected.size() > 0) begin
            want = expected.pop_front();
            check_word("ex_out", ex_out, want.out);
            check_word("ex_b_data", ex_b_data, want.b_data);
            check_regnum("ex_w_regnum", ex_w_regnum, want.w_regnum);
            check_bit("ex_write_enable", ex_write_enable, want.we);
            check_bit("ex_overflow", ex_overflow, want.overflow);
            check_bit("ex_zero", ex_zero, want.zero);
            check_word("ex_slt_out", ex_slt_out, want.slt);
            check_word("mem_data", mem_data, want.mem_data);
            check_regnum("mem_w_regnum", mem_w_regnum, want.mem_w_regnum);
        end
    end

    initial begin
        #((N_INSTR + 20) * 10);
        $display("Watchdog expired before all instructions were checked");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        t = '0;
        t.reset = 1'b1;
        for (int r = 0; r < 32; r++) regfile[r] = {rand32(), rand32()};
        regfile[0] = '0;
        regfile[1] = 64'h7fff_ffff_ffff_ffff;
        regfile[2] = 64'd1;
        regfile[3] = 64'h8000_0000_0000_0000;
        regfile[4] = '1;
        apply(t);
        ex_sh = '0;
        mem_sh = '0;
        expected.push_back('0);
        expected.push_back('0);
        repeat (2) @(posedge clock);

        // Signed limits, zero result and every ALU operation.
        issue(alu_instr(ADD, REG, SLT_NONE, 5'd1, 5'd2, 5'd20, 16'h0));
        issue(alu_instr(ADD, REG, SLT_NONE, 5'd3, 5'd4, 5'd20, 16'h0));
        issue(alu_instr(SUB, REG, SLT_NONE, 5'd3, 5'd2, 5'd20, 16'h0));
        issue(alu_instr(SUB, REG, SLT_NONE, 5'd1, 5'd4, 5'd20, 16'h0));
        issue(alu_instr(SUB, REG, SLT_NONE, 5'd2, 5'd2, 5'd20, 16'h0));
        for (int op = 0; op < 6; op++) begin
            issue(alu_instr(alu_op_t'(op), REG, SLT_NONE, 5'd5, 5'd6, 5'd20, 16'h0));
        end

        issue(alu_instr(ADD, SIGN_IMM, SLT_NONE, 5'd5, 5'd0, 5'd22, 16'h8001));
        issue(alu_instr(ADD, ZERO_IMM, SLT_NONE, 5'd5, 5'd0, 5'd22, 16'h8001));
        issue(alu_instr(OR, ZERO_IMM, SLT_NONE, 5'd0, 5'd0, 5'd22, 16'hbeef));
        t = alu_instr(ADD, REG, SLT_NONE, 5'd0, 5'd0, 5'd22, 16'hfff0);
        t.lui = 1'b1;
        issue(t);

        for (int amt = 0; amt < 32; amt++) begin
            issue(shift_instr(5'd7, shamt_t'(amt), 1'b0, 1'b0, P32_NONE));
            issue(shift_instr(5'd7, shamt_t'(amt), 1'b1, 1'b0, P32_NONE));
        end
        issue(shift_instr(5'd7, 5'd4, 1'b0, 1'b1, P32_NONE));
        issue(shift_instr(5'd7, 5'd4, 1'b1, 1'b0, P32_LEFT));
        issue(shift_instr(5'd7, 5'd4, 1'b0, 1'b0, P32_RIGHT));

        issue(alu_instr(SUB, REG, SLT_SIGNED, 5'd3, 5'd2, 5'd23, 16'h0));
        issue(alu_instr(SUB, REG, SLT_SIGNED, 5'd2, 5'd3, 5'd23, 16'h0));
        issue(alu_instr(SUB, REG, SLT_SIGNED, 5'd4, 5'd2, 5'd23, 16'h0));
        issue(alu_instr(SUB, REG, SLT_UNSIGNED, 5'd3, 5'd2, 5'd23, 16'h0));
        issue(alu_instr(SUB, REG, SLT_UNSIGNED, 5'd2, 5'd3, 5'd23, 16'h0));

        // Dependent chains through EX and MEM, then register zero and a non-writing entry.
        issue(alu_instr(ADD, REG, SLT_NONE, 5'd2, 5'd2, 5'd8, 16'h0));
        issue(alu_instr(ADD, REG, SLT_NONE, 5'd8, 5'd8, 5'd9, 16'h0));
        issue(alu_instr(ADD, REG, SLT_NONE, 5'd8, 5'd9, 5'd10, 16'h0));
        issue(alu_instr(XOR, REG, SLT_NONE, 5'd1, 5'd2, 5'd10, 16'h0));
        issue(alu_instr(SUB, REG, SLT_NONE, 5'd10, 5'd10, 5'd11, 16'h0));
        issue(alu_instr(ADD, REG, SLT_NONE, 5'd1, 5'd1, 5'd0, 16'h0));
        issue(alu_instr(ADD, REG, SLT_NONE, 5'd0, 5'd0, 5'd12, 16'h0));
        t = alu_instr(ADD, REG, SLT_NONE, 5'd1, 5'd2, 5'd13, 16'h0);
        t.write_enable = 1'b0;
        issue(t);
        issue(alu_instr(OR, REG, SLT_NONE, 5'd13, 5'd13, 5'd14, 16'h0));

        t = alu_instr(ADD, REG, SLT_NONE, 5'd1, 5'd1, 5'd15, 16'h0);
        t.flush = 1'b1;
        issue(t);
        issue(alu_instr(OR, REG, SLT_NONE, 5'd15, 5'd15, 5'd16, 16'h0));
        issue(alu_instr(OR, REG, SLT_NONE, 5'd15, 5'd16, 5'd17, 16'h0));
        t = '0;
        t.reset = 1'b1;
        issue(t);
        issue(alu_instr(OR, REG, SLT_NONE, 5'd16, 5'd17, 5'd18, 16'h0));

        while (slots < N_INSTR) issue(random_instr());
        @(negedge clock);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
hdl/exec_pkg.sv
hdl/alu.sv
hdl/barrel_shifter.sv
hdl/forward_unit.sv
hdl/exec_stage.sv
hdl/exec_top.sv
tests/tb_exec_top.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - hdl/exec_pkg.sv
  - hdl/alu.sv
  - hdl/barrel_shifter.sv
  - hdl/forward_unit.sv
  - hdl/exec_stage.sv
  - hdl/exec_top.sv
  - target: test
    files:
      - tests/tb_exec_top.sv
